//--- gcm_key_update.f
+incdir+include
hdl/gcm_types_pkg.sv
hdl/key_ctrl_pkg.sv
hdl/key_update_fsm.sv
hdl/key_expander.sv
hdl/h_power_calc.sv
hdl/key_store_arb.sv
hdl/gcm_key_update.sv
verif/tb_clock_gen.sv
verif/gcm_key_update_tb.sv

//--- hdl/gcm_key_update.sv
`timescale 1ns/1ps

module gcm_key_update
(
    input  logic                      i_clock,
    input  logic                      i_reset,
    input  logic                      i_valid,
    input  logic                      i_key_update,
    input  gcm_types_pkg::block_t     i_key,
    input  logic                      i_sop_pre,
    input  logic                      i_sop,
    input  logic                      i_h_valid,
    input  gcm_types_pkg::block_t     i_h,
    input  gcm_types_pkg::ks_addr_t   i_rd_addr,
    output logic                      o_trigger_h_calc,
    output logic                      o_key_update_done,
    output key_ctrl_pkg::key_state_t  o_state,
    output logic                      o_active_bank,
    output gcm_types_pkg::block_t     o_rd_data
);
    import gcm_types_pkg::*;

    logic     key_sched_trigger;
    logic     key_sched_ready;
    logic     h_powers_trigger;
    logic     h_powers_ready;
    logic     switch_banks;
    logic     lock_done;
    logic     exp_wr_req;
    ks_addr_t exp_wr_addr;
    block_t   exp_wr_data;
    logic     exp_grant;
    logic     hpow_wr_req;
    ks_addr_t hpow_wr_addr;
    block_t   hpow_wr_data;
    logic     hpow_grant;

    key_update_fsm u_key_update_fsm
    (
        .i_clock                  (i_clock),
        .i_reset                  (i_reset),
        .i_valid                  (i_valid),
        .i_key_update             (i_key_update),
        .i_key_sched_ready        (key_sched_ready),
        .i_sop_pre                (i_sop_pre),
        .i_h_valid                (i_h_valid),
        .i_h_powers_ready         (h_powers_ready),
        .i_sop                    (i_sop),
        .i_lock_done              (lock_done),
        .o_trigger_key_sched_calc (key_sched_trigger),
        .o_trigger_h_calc         (o_trigger_h_calc),
        .o_trigger_h_powers_calc  (h_powers_trigger),
        .o_switch_banks           (switch_banks),
        .o_key_update_done        (o_key_update_done),
        .o_state                  (o_state)
    );

    key_expander u_key_expander
    (
        .i_clock   (i_clock),
        .i_reset   (i_reset),
        .i_start   (key_sched_trigger),
        .i_key     (i_key),
        .i_grant   (exp_grant),
        .o_wr_req  (exp_wr_req),
        .o_wr_addr (exp_wr_addr),
        .o_wr_data (exp_wr_data),
        .o_ready   (key_sched_ready)
    );

    // a new key request cancels any power calculation in flight
    h_power_calc u_h_power_calc
    (
        .i_clock   (i_clock),
        .i_reset   (i_reset),
        .i_start   (h_powers_trigger),
        .i_abort   (key_sched_trigger),
        .i_h       (i_h),
        .i_grant   (hpow_grant),
        .o_wr_req  (hpow_wr_req),
        .o_wr_addr (hpow_wr_addr),
        .o_wr_data (hpow_wr_data),
        .o_ready   (h_powers_ready)
    );

    key_store_arb u_key_store_arb
    (
        .i_clock        (i_clock),
        .i_reset        (i_reset),
        .i_exp_wr_req   (exp_wr_req),
        .i_exp_wr_addr  (exp_wr_addr),
        .i_exp_wr_data  (exp_wr_data),
        .i_hpow_wr_req  (hpow_wr_req),
        .i_hpow_wr_addr (hpow_wr_addr),
        .i_hpow_wr_data (hpow_wr_data),
        .i_switch_banks (switch_banks),
        .i_rd_addr      (i_rd_addr),
        .o_grant_exp    (exp_grant),
        .o_grant_hpow   (hpow_grant),
        .o_lock_done    (lock_done),
        .o_rd_data      (o_rd_data),
        .o_active_bank  (o_active_bank)
    );

endmodule

//--- hdl/gcm_types_pkg.sv
`include "gcm_key_consts.svh"

package gcm_types_pkg;

    // keys, round keys and H powers
    typedef logic [`NB_BLOCK-1:0] block_t;

    typedef logic [`NB_KS_ADDR-1:0] ks_addr_t;  // key store entry

    typedef logic [31:0] word_t;                // one key schedule column

endpackage

//--- hdl/h_power_calc.sv
`timescale 1ns/1ps
`include "gcm_key_consts.svh"

module h_power_calc
(
    input  logic                     i_clock,
    input  logic                     i_reset,
    input  logic                     i_start,
    input  logic                     i_abort,
    input  gcm_types_pkg::block_t    i_h,
    input  logic                     i_grant,
    output logic                     o_wr_req,
    output gcm_types_pkg::ks_addr_t  o_wr_addr,
    output gcm_types_pkg::block_t    o_wr_data,
    output logic                     o_ready
);
    import gcm_types_pkg::*;

    // x^128 + x^7 + x^2 + x + 1 in reflected order
    localparam block_t R_POLY = {8'he1, 120'h0};

    block_t h_reg;
    block_t pow;                                        // running power of H
    block_t z;
    block_t v;
    block_t x_sh;
    block_t z_next;
    logic [$clog2(`NB_BLOCK)-1:0]   bit_cnt;
    logic [$clog2(`N_H_POWERS)-1:0] idx;                // power being produced, minus one
    logic   wr_pend;
    logic   mul_on;

    // gcm bit 0 is the msb of the vector
    assign z_next = x_sh[`NB_BLOCK-1] ? (z ^ v) : z;

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            wr_pend <= 1'b0;
            mul_on  <= 1'b0;
            idx     <= '0;
            bit_cnt <= '0;
            o_ready <= 1'b0;
        end
        else
        begin
            o_ready <= 1'b0;
            if (i_abort)
            begin
                wr_pend <= 1'b0;
                mul_on  <= 1'b0;
            end
            else if (i_start)                           // H^1 goes out first
            begin
                wr_pend <= 1'b1;
                mul_on  <= 1'b0;
                idx     <= '0;
            end
            else if (wr_pend && i_grant)
            begin
                wr_pend <= 1'b0;
                if (int'(idx) == `N_H_POWERS - 1)
                begin
                    o_ready <= 1'b1;
                end
                else
                begin
                    mul_on  <= 1'b1;
                    bit_cnt <= '0;
                end
            end
            else if (mul_on)
            begin
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt == '1)                      // 128th bit done
                begin
                    mul_on  <= 1'b0;
                    wr_pend <= 1'b1;
                    idx     <= idx + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (i_start)
        begin
            h_reg <= i_h;
            pow   <= i_h;
        end
        else if (wr_pend && i_grant)
        begin
            z    <= '0;
            v    <= h_reg;
            x_sh <= pow;
        end
        else if (mul_on)
        begin
            z    <= z_next;
            v    <= v[0] ? ((v >> 1) ^ R_POLY) : (v >> 1);
            x_sh <= x_sh << 1;
            if (bit_cnt == '1)
                pow <= z_next;
        end
    end

    assign o_wr_req  = wr_pend;
    assign o_wr_addr = ks_addr_t'(`KS_H_BASE + int'(idx));
    assign o_wr_data = pow;

endmodule

//--- hdl/key_ctrl_pkg.sv
package key_ctrl_pkg;

    typedef enum logic [2:0]
    {
        IDLE,
        WAIT_KEY_SCHED,
        WAIT_SOP_PRE,
        WAIT_H,
        WAIT_H_POWERS,
        WAIT_SOP,
        WAIT_LOCK_DONE
    } key_state_t;

    // key store write requesters
    typedef enum logic
    {
        EXPANDER,
        HPOWER
    } writer_t;

endpackage

//--- hdl/key_expander.sv
`timescale 1ns/1ps
`include "gcm_key_consts.svh"

module key_expander
(
    input  logic                     i_clock,
    input  logic                     i_reset,
    input  logic                     i_start,
    input  gcm_types_pkg::block_t    i_key,
    input  logic                     i_grant,
    output logic                     o_wr_req,
    output gcm_types_pkg::ks_addr_t  o_wr_addr,
    output gcm_types_pkg::block_t    o_wr_data,
    output logic                     o_ready
);
    import gcm_types_pkg::*;

    localparam ks_addr_t LAST_ROUND = ks_addr_t'(`N_ROUND_KEYS - 1);

    block_t     round_key;
    block_t     next_key;
    ks_addr_t   round;
    logic [7:0] rcon;
    logic       busy;
    word_t      w0;
    word_t      w1;
    word_t      w2;
    word_t      w3;
    word_t      temp;

    function automatic logic [7:0] xtime(input logic [7:0] a);
        return {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
    endfunction

    function automatic logic [7:0] gf8_mul(input logic [7:0] a, input logic [7:0] b);
        logic [7:0] p;
        logic [7:0] x;
        p = 8'h00;
        x = a;
        for (int i = 0; i < 8; i++)
        begin
            if (b[i])
                p = p ^ x;
            x = xtime(x);
        end
        return p;
    endfunction

    // inverse as a^254, then the affine map
    function automatic logic [7:0] sbox(input logic [7:0] a);
        logic [7:0] inv;
        logic [7:0] sq;
        inv = 8'h01;
        sq  = a;
        for (int i = 0; i < 7; i++)
        begin
            sq  = gf8_mul(sq, sq);
            inv = gf8_mul(inv, sq);
        end
        return inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]} ^ {inv[4:0], inv[7:5]}
               ^ {inv[3:0], inv[7:4]} ^ 8'h63;
    endfunction

    function automatic word_t sub_word(input word_t w);
        return {sbox(w[31:24]), sbox(w[23:16]), sbox(w[15:8]), sbox(w[7:0])};
    endfunction

    always_comb
    begin
        w0       = round_key[127:96];
        w1       = round_key[95:64];
        w2       = round_key[63:32];
        w3       = round_key[31:0];
        temp     = sub_word({w3[23:0], w3[31:24]}) ^ {rcon, 24'h000000};  // rotword first
        next_key = {w0 ^ temp,
                    w1 ^ w0 ^ temp,
                    w2 ^ w1 ^ w0 ^ temp,
                    w3 ^ w2 ^ w1 ^ w0 ^ temp};
    end

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            busy    <= 1'b0;
            round   <= '0;
            rcon    <= 8'h01;
            o_ready <= 1'b0;
        end
        else
        begin
            o_ready <= 1'b0;
            if (i_start)                                // restart from the cipher key
            begin
                busy  <= 1'b1;
                round <= '0;
                rcon  <= 8'h01;
            end
            else if (busy && i_grant)
            begin
                if (round == LAST_ROUND)
                begin
                    busy    <= 1'b0;
                    o_ready <= 1'b1;                    // last key just landed
                end
                else
                begin
                    round <= round + 1'b1;
                    rcon  <= xtime(rcon);
                end
            end
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (i_start)
            round_key <= i_key;
        else if (busy && i_grant)
            round_key <= next_key;
    end

    assign o_wr_req  = busy;                            // held until granted
    assign o_wr_addr = round;
    assign o_wr_data = round_key;

endmodule

//--- hdl/key_store_arb.sv
`timescale 1ns/1ps
`include "gcm_key_consts.svh"

module key_store_arb
(
    input  logic                     i_clock,
    input  logic                     i_reset,
    input  logic                     i_exp_wr_req,
    input  gcm_types_pkg::ks_addr_t  i_exp_wr_addr,
    input  gcm_types_pkg::block_t    i_exp_wr_data,
    input  logic                     i_hpow_wr_req,
    input  gcm_types_pkg::ks_addr_t  i_hpow_wr_addr,
    input  gcm_types_pkg::block_t    i_hpow_wr_data,
    input  logic                     i_switch_banks,
    input  gcm_types_pkg::ks_addr_t  i_rd_addr,
    output logic                     o_grant_exp,
    output logic                     o_grant_hpow,
    output logic                     o_lock_done,
    output gcm_types_pkg::block_t    o_rd_data,
    output logic                     o_active_bank
);
    import gcm_types_pkg::*;
    import key_ctrl_pkg::*;

    localparam int BANK_DEPTH = 1 << `NB_KS_ADDR;

    block_t   mem [0:2*BANK_DEPTH-1];                   // {bank, addr}
    writer_t  rr_prio;                                  // preferred writer on a tie
    logic     wr_en;
    ks_addr_t wr_addr;
    block_t   wr_data;

    assign o_grant_exp  = i_exp_wr_req && (!i_hpow_wr_req || rr_prio == EXPANDER);
    assign o_grant_hpow = i_hpow_wr_req && (!i_exp_wr_req || rr_prio == HPOWER);

    assign wr_en   = o_grant_exp || o_grant_hpow;
    assign wr_addr = o_grant_hpow ? i_hpow_wr_addr : i_exp_wr_addr;
    assign wr_data = o_grant_hpow ? i_hpow_wr_data : i_exp_wr_data;

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            rr_prio       <= EXPANDER;
            o_active_bank <= 1'b0;
            o_lock_done   <= 1'b0;
        end
        else
        begin
            o_lock_done <= i_switch_banks;              // one cycle after the swap
            if (i_switch_banks)
                o_active_bank <= ~o_active_bank;
            if (o_grant_exp)
                rr_prio <= HPOWER;                      // other side goes next
            else if (o_grant_hpow)
                rr_prio <= EXPANDER;
        end
    end

    // writes land in the shadow bank only
    always_ff @(posedge i_clock)
    begin
        if (wr_en)
            mem[{~o_active_bank, wr_addr}] <= wr_data;
        o_rd_data <= mem[{o_active_bank, i_rd_addr}];
    end

endmodule

//--- hdl/key_update_fsm.sv
`timescale 1ns/1ps

module key_update_fsm
(
    input  logic                      i_clock,
    input  logic                      i_reset,
    input  logic                      i_valid,
    input  logic                      i_key_update,
    input  logic                      i_key_sched_ready,
    input  logic                      i_sop_pre,
    input  logic                      i_h_valid,
    input  logic                      i_h_powers_ready,
    input  logic                      i_sop,
    input  logic                      i_lock_done,
    output logic                      o_trigger_key_sched_calc,
    output logic                      o_trigger_h_calc,
    output logic                      o_trigger_h_powers_calc,
    output logic                      o_switch_banks,
    output logic                      o_key_update_done,
    output key_ctrl_pkg::key_state_t  o_state
);
    import key_ctrl_pkg::*;

    key_state_t state;
    key_state_t state_next;
    logic       restart;

    // a new request wins over any event of the current state
    assign restart = i_key_update;

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            state <= IDLE;
        end
        else if (i_valid)                               // state moves on enabled edges only
        begin
            state <= state_next;
        end
    end

    always_comb
    begin
        state_next              = state;
        o_trigger_h_calc        = 1'b0;
        o_trigger_h_powers_calc = 1'b0;
        o_switch_banks          = 1'b0;
        o_key_update_done       = 1'b0;

        case (state)
            IDLE:
            begin
                state_next = IDLE;
            end
            WAIT_KEY_SCHED:
            begin
                if (i_key_sched_ready)
                    state_next = WAIT_SOP_PRE;
            end
            WAIT_SOP_PRE:
            begin
                o_trigger_h_calc = i_sop_pre && !restart;   // cipher computes H
                if (i_sop_pre)
                    state_next = WAIT_H;
            end
            WAIT_H:
            begin
                o_trigger_h_powers_calc = i_h_valid && !restart;
                if (i_h_valid)
                    state_next = WAIT_H_POWERS;
            end
            WAIT_H_POWERS:
            begin
                if (i_h_powers_ready)
                    state_next = WAIT_SOP;
            end
            WAIT_SOP:
            begin
                o_switch_banks = i_sop && !restart;     // swap at packet boundary
                if (i_sop)
                    state_next = WAIT_LOCK_DONE;
            end
            WAIT_LOCK_DONE:
            begin
                o_key_update_done = i_lock_done && !restart;
                if (i_lock_done)
                    state_next = IDLE;
            end
            default:
            begin
                state_next = IDLE;
            end
        endcase

        if (restart)
            state_next = WAIT_KEY_SCHED;
    end

    assign o_trigger_key_sched_calc = i_key_update;     // same in every state
    assign o_state                  = state;

endmodule

//--- include/gcm_key_consts.svh
`ifndef GCM_KEY_CONSTS_SVH
`define GCM_KEY_CONSTS_SVH

// block, round key and H power width
`define NB_BLOCK        128

`define N_ROUND_KEYS    11      // aes-128 schedule
`define N_H_POWERS      4       // H^1 .. H^4
`define NB_KS_ADDR      4       // 16 entries per bank

// H^k lives at KS_H_BASE + k - 1
`define KS_H_BASE       11

`endif

//--- verif/gcm_key_update_tb.sv
`timescale 1ns/1ps
`include "gcm_key_consts.svh"

module gcm_key_update_tb;
    import gcm_types_pkg::*;
    import key_ctrl_pkg::*;

    localparam int S_KEY     = 0;
    localparam int S_SOP_PRE = 1;
    localparam int S_H       = 2;
    localparam int S_SOP     = 3;

    localparam block_t FIPS_KEY       = 128'h2b7e151628aed2a6abf7158809cf4f3c;
    localparam block_t KEY_SECOND     = 128'h000102030405060708090a0b0c0d0e0f;
    localparam block_t KEY_SECOND_R10 = 128'h13111d7fe3944a17f307a78b4d2b30c5;  // FIPS-197 C.1
    localparam block_t H_FIRST        = 128'h66e94bd4ef8a2c3b884cfa59ca342b2e;
    localparam block_t H_ABORT        = 128'hb83b533708bf535d0aa6e52980d53b78;
    localparam block_t H_SECOND       = 128'hacbef20579b4b8ebce889bac8732dad7;

    logic       clock;
    logic       reset;
    logic       valid;
    logic       key_update;
    block_t     key;
    logic       sop_pre;
    logic       sop;
    logic       h_valid;
    block_t     h;
    ks_addr_t   rd_addr;
    logic       trigger_h_calc;
    logic       key_update_done;
    key_state_t state;
    logic       active_bank;
    block_t     rd_data;

    logic        rd_check;                              // read result is due
    block_t      rd_expect;
    logic        seen_update;
    key_state_t  prev_state;
    logic        prev_bank;
    logic        prev_swap_cond;
    logic [31:0] lfsr_state;

    tb_clock_gen u_clock_gen
    (
        .o_clock (clock),
        .o_reset (reset)
    );

    gcm_key_update u_gcm_key_update
    (
        .i_clock           (clock),
        .i_reset           (reset),
        .i_valid           (valid),
        .i_key_update      (key_update),
        .i_key             (key),
        .i_sop_pre         (sop_pre),
        .i_sop             (sop),
        .i_h_valid         (h_valid),
        .i_h               (h),
        .i_rd_addr         (rd_addr),
        .o_trigger_h_calc  (trigger_h_calc),
        .o_key_update_done (key_update_done),
        .o_state           (state),
        .o_active_bank     (active_bank),
        .o_rd_data         (rd_data)
    );

    task automatic end_in_failure();
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string sig, input block_t exp_val, input block_t act_val);
        $display("[ERROR] %0t %s expected %0h got %0h", $time, sig, exp_val, act_val);
        end_in_failure();
    endtask

    task automatic report_timeout(input string what);
        $display("timed out at %0t while waiting for %s", $time, what);
        end_in_failure();
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            value = (value << 1) | int'(lfsr_state[0]);
        end
    endtask

    // multiply in GF(2^128) with bit 0 of a block as its msb
    function automatic block_t gcm_mult(input block_t x, input block_t y);
        block_t z;
        block_t v;
        z = '0;
        v = y;
        for (int i = 0; i < `NB_BLOCK; i++)
        begin
            if (x[`NB_BLOCK - 1 - i])
                z = z ^ v;
            v = v[0] ? ((v >> 1) ^ {8'he1, 120'h0}) : (v >> 1);
        end
        return z;
    endfunction

    // FIPS-197 appendix A.1 expansion
    function automatic block_t fips_round_key(input int r);
        case (r)
            0:       return FIPS_KEY;
            1:       return 128'ha0fafe1788542cb123a339392a6c7605;
            2:       return 128'hf2c295f27a96b9435935807a7359f67f;
            3:       return 128'h3d80477d4716fe3e1e237e446d7a883b;
            4:       return 128'hef44a541a8525b7fb671253bdb0bad00;
            5:       return 128'hd4d1c6f87c839d87caf2b8bc11f915bc;
            6:       return 128'h6d88a37a110b3efddbf98641ca0093fd;
            7:       return 128'h4e54f70e5f5fc9f384a64fb24ea6dc4f;
            8:       return 128'head27321b58dbad2312bf5607f8d292f;
            9:       return 128'hac7766f319fadc2128d12941575c006e;
            default: return 128'hd014f9a8c9ee2589e13f0cc8b6630ca6;
        endcase
    endfunction

    // one-cycle strobe under the given clock enable
    task automatic strobe(input int sel, input block_t data, input logic en);
        @(posedge clock);
        valid <= en;
        case (sel)
            S_KEY:
            begin
                key         <= data;
                key_update  <= 1'b1;
                seen_update <= 1'b1;
            end
            S_SOP_PRE:
            begin
                sop_pre <= 1'b1;
            end
            S_H:
            begin
                h       <= data;
                h_valid <= 1'b1;
            end
            default:
            begin
                sop <= 1'b1;
            end
        endcase
        @(posedge clock);
        key_update <= 1'b0;
        sop_pre    <= 1'b0;
        h_valid    <= 1'b0;
        sop        <= 1'b0;
    endtask

    task automatic random_gap(input logic drop_valid);
        int len;
        int b;
        take_bits(3, len);
        for (int i = 0; i <= len; i++)
        begin
            @(posedge clock);
            take_bits(1, b);
            if (drop_valid)
                valid <= b[0];                          // random enable drops
        end
    endtask

    task automatic wait_reset_release();
        int n;
        n = 0;
        while (reset && n < 20)
        begin
            @(negedge clock);
            n++;
        end
        if (reset)
            report_timeout("reset release");
    endtask

    task automatic wait_state(input key_state_t s, input int limit, input string what);
        int n;
        n = 0;
        while (state != s && n < limit)
        begin
            @(negedge clock);
            n++;
        end
        if (state != s)
            report_timeout(what);
    endtask

    task automatic wait_done();
        int n;
        n = 0;
        while (!key_update_done && n < 5)
        begin
            @(negedge clock);
            n++;
        end
        if (!key_update_done)
            report_timeout("key update done");
    endtask

    // single read with one cycle of latency
    task automatic read_check(input ks_addr_t addr, input block_t exp_val);
        @(posedge clock);
        rd_addr   <= addr;
        rd_expect <= exp_val;
        repeat (2) @(posedge clock);
        rd_check <= 1'b1;
        @(posedge clock);
        rd_check <= 1'b0;
    endtask

    task automatic check_h_powers(input block_t h_val);
        block_t p;
        p = h_val;
        for (int k = 0; k < `N_H_POWERS; k++)
        begin
            read_check(ks_addr_t'(`KS_H_BASE + k), p);
            p = gcm_mult(p, h_val);
        end
    endtask

    task automatic expand_phase(input block_t key_val);
        strobe(S_KEY, key_val, 1'b1);
        wait_state(WAIT_SOP_PRE, 40, "key schedule");
    endtask

    task automatic finish_update(input block_t h_val);
        random_gap(1'b1);
        strobe(S_SOP_PRE, '0, 1'b1);
        wait_state(WAIT_H, 10, "H request");
        random_gap(1'b0);
        strobe(S_H, h_val, 1'b1);
        wait_state(WAIT_SOP, 1000, "H powers");
        random_gap(1'b1);
        strobe(S_SOP, '0, 1'b1);
        wait_done();
    endtask

    always @(posedge clock)
    begin
        prev_state     <= state;
        prev_bank      <= active_bank;
        prev_swap_cond <= sop && !key_update && (state == WAIT_SOP);
    end

    idle_state_a: assert property (@(posedge clock) disable iff (reset)
        !seen_update |-> state == IDLE)
        else report_mismatch("o_state", IDLE, $sampled(state));

    idle_done_a: assert property (@(posedge clock) disable iff (reset)
        !seen_update |-> !key_update_done)
        else report_mismatch("o_key_update_done", 0, 1);

    idle_trigger_a: assert property (@(posedge clock) disable iff (reset)
        !seen_update |-> !trigger_h_calc)
        else report_mismatch("o_trigger_h_calc", 0, 1);

    rd_data_a: assert property (@(posedge clock) disable iff (reset)
        rd_check |-> rd_data == rd_expect)
        else report_mismatch("o_rd_data", rd_expect, $sampled(rd_data));

    bank_swap_a: assert property (@(posedge clock) disable iff (reset)
        (active_bank != prev_bank) |-> prev_swap_cond)
        else report_mismatch("o_active_bank", $sampled(prev_bank), $sampled(active_bank));

    // done follows the swap by exactly one cycle
    done_timing_a: assert property (@(posedge clock) disable iff (reset)
        key_update_done == (active_bank != prev_bank))
        else report_mismatch("o_key_update_done", $sampled(active_bank != prev_bank),
                             $sampled(key_update_done));

    restart_a: assert property (@(posedge clock) disable iff (reset)
        key_update && valid |=> state == WAIT_KEY_SCHED)
        else report_mismatch("o_state", WAIT_KEY_SCHED, $sampled(state));

    // H request exactly on a pre-start mark after a finished expansion
    h_trigger_a: assert property (@(posedge clock) disable iff (reset)
        trigger_h_calc == (sop_pre && !key_update && state == WAIT_SOP_PRE))
        else report_mismatch("o_trigger_h_calc",
                             $sampled(sop_pre && !key_update && state == WAIT_SOP_PRE),
                             $sampled(trigger_h_calc));

    hold_state_a: assert property (@(posedge clock) disable iff (reset)
        !valid |=> state == prev_state)
        else report_mismatch("o_state", $sampled(prev_state), $sampled(state));

    initial
    begin
        valid       = 1'b1;
        key_update  = 1'b0;
        key         = '0;
        sop_pre     = 1'b0;
        sop         = 1'b0;
        h_valid     = 1'b0;
        h           = '0;
        rd_addr     = '0;
        rd_check    = 1'b0;
        rd_expect   = '0;
        seen_update = 1'b0;
        lfsr_state  = 32'hc396;
        wait_reset_release();

        // stray strobes in IDLE start nothing
        strobe(S_SOP_PRE, '0, 1'b1);
        strobe(S_SOP, '0, 1'b0);
        strobe(S_H, H_ABORT, 1'b1);
        random_gap(1'b1);

        expand_phase(FIPS_KEY);
        finish_update(H_FIRST);
        for (int r = 0; r < `N_ROUND_KEYS; r++)
        begin
            read_check(ks_addr_t'(r), fips_round_key(r));
        end
        check_h_powers(H_FIRST);

        // second key while the old set stays visible
        expand_phase(KEY_SECOND);
        read_check(ks_addr_t'(0), fips_round_key(0));
        read_check(ks_addr_t'(10), fips_round_key(10));
        strobe(S_SOP_PRE, '0, 1'b1);
        wait_state(WAIT_H, 10, "H request");
        strobe(S_H, H_ABORT, 1'b1);
        wait_state(WAIT_H_POWERS, 10, "H power phase");
        check_h_powers(H_FIRST);
        strobe(S_KEY, KEY_SECOND, 1'b1);                // restart mid power phase
        strobe(S_SOP_PRE, '0, 1'b1);                    // expansion still running
        wait_state(WAIT_SOP_PRE, 40, "key schedule after restart");

        // strobes under a low enable leave the state alone
        strobe(S_SOP_PRE, '0, 1'b0);
        strobe(S_SOP, '0, 1'b0);
        strobe(S_H, H_ABORT, 1'b0);
        finish_update(H_SECOND);
        read_check(ks_addr_t'(0), KEY_SECOND);
        read_check(ks_addr_t'(10), KEY_SECOND_R10);
        check_h_powers(H_SECOND);

        $display("STATUS: PASS");
        $finish;
    end

endmodule

//--- verif/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen
(
    output logic o_clock,
    output logic o_reset
);
    initial
    begin
        o_clock = 1'b0;
        forever #50 o_clock = ~o_clock;                 // 100 ns period
    end

    initial
    begin
        o_reset = 1'b1;
        repeat (10) @(posedge o_clock);
        o_reset <= 1'b0;
    end

endmodule
